//--- flist.f
+incdir+include
hdl/tensor_pkg.sv
hdl/fifo_queue.sv
hdl/dot_product_unit.sv
hdl/step_sequencer.sv
hdl/tensor_threadgroup.sv
hdl/tensor_dpu.sv
testbench/tb_tensor_dpu.sv

//--- run_sim.sh
#!/bin/sh
# compile the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_tensor_dpu \
    --Mdir obj_dir -o sim_tensor_dpu \
    && ./obj_dir/sim_tensor_dpu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0

//--- testbench/tb_tensor_dpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tensor_dpu
    import tensor_pkg::*;
();
    localparam int num_tiles    = 200;
    // two cycles per tile times ten for random gaps and stalls
    localparam int max_cycles   = num_tiles * 2 * 10;
    localparam int reset_cycles = 4;
    localparam int valid_pct    = 70;
    localparam int ready_pct    = 60;
    // long back-pressure window that fills the queues
    localparam int stall_start  = 120;
    localparam int stall_len    = 40;

    logic     clk;
    logic     reset;
    logic     valid_in;
    logic     ready_in;
    tile_in_t operands;
    wid_t     wid;
    logic     valid_out;
    logic     ready_out;
    cd_tile_t d_tile;
    wid_t     d_wid;

    integer   seed          = 42;
    int       errors        = 0;
    int       accepted      = 0;
    int       taken         = 0;
    int       cycles        = 0;
    bit       accepted_flag = 1'b0;
    bit       in_stretch    = 1'b0;
    bit       saw_ready_low = 1'b0;
    bit       held_prev     = 1'b0;
    cd_tile_t held_tile;
    wid_t     held_wid;
    cd_tile_t exp_tile_q [$];
    wid_t     exp_wid_q [$];

    tensor_dpu tensor_dpu_i (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .operands  (operands),
        .wid       (wid),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .d_tile    (d_tile),
        .d_wid     (d_wid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic int unsigned draw_pct();
        return {$random(seed)} % 100;
    endfunction

    task automatic random_tile(output tile_in_t t);
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 2; k++) begin
                t.a[r][k] = $random(seed);
            end
        end
        for (int k = 0; k < 2; k++) begin
            for (int c = 0; c < 4; c++) begin
                t.b[k][c] = $random(seed);
            end
        end
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                t.c[r][c] = $random(seed);
            end
        end
    endtask

    // d[r][c] = c[r][c] + a[r][0]*b[0][c] + a[r][1]*b[1][c] wrapping at 32 bits
    function automatic cd_tile_t model_d(input tile_in_t t);
        cd_tile_t d;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                d[r][c] = t.c[r][c] + t.a[r][0] * t.b[0][c] + t.a[r][1] * t.b[1][c];
            end
        end
        return d;
    endfunction

    task automatic compare_tile(input cd_tile_t exp_tile, input wid_t exp_wid);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                check_value($sformatf("d_tile[%0d][%0d]", r, c), d_tile[r][c],
                            exp_tile[r][c]);
            end
        end
        check_value("d_wid", 32'(d_wid), 32'(exp_wid));
    endtask

    // new inputs shortly after each rising edge
    task automatic drive_cycle();
        in_stretch = (cycles >= stall_start) && (cycles < stall_start + stall_len);
        ready_out  = in_stretch ? 1'b0 : (draw_pct() < ready_pct);
        // an offered tile stays on the inputs until it is taken
        if (!valid_in || accepted_flag) begin
            if (accepted < num_tiles && draw_pct() < valid_pct) begin
                random_tile(operands);
                wid      = wid_t'($random(seed));
                valid_in = 1'b1;
            end else begin
                valid_in = 1'b0;
            end
        end
    endtask

    // scoreboard sampled mid-cycle where every signal is settled
    always @(negedge clk) begin
        if (!reset) begin
            if (held_prev) begin
                check_value("valid_out", 32'(valid_out), 32'd1);
                compare_tile(held_tile, held_wid);
            end
            if (valid_out && ready_out) begin
                taken++;
                if (exp_tile_q.size() == 0) begin
                    errors++;
                    $display("tile taken at %0t with no tile outstanding", $time);
                end else begin
                    compare_tile(exp_tile_q.pop_front(), exp_wid_q.pop_front());
                end
            end
            held_prev = valid_out && !ready_out;
            held_tile = d_tile;
            held_wid  = d_wid;

            accepted_flag = 1'b0;
            if (valid_in && ready_in) begin
                exp_tile_q.push_back(model_d(operands));
                exp_wid_q.push_back(wid);
                accepted++;
                accepted_flag = 1'b1;
            end
            if (in_stretch && !ready_in) begin
                saw_ready_low = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles with %0d of %0d tiles taken, %0d errors",
                     cycles, taken, num_tiles, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        reset     = 1'b1;
        valid_in  = 1'b0;
        ready_out = 1'b1;
        operands  = '0;
        wid       = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        check_value("valid_out", 32'(valid_out), 32'd0);
        check_value("ready_in", 32'(ready_in), 32'd1);

        while (taken < num_tiles) begin
            @(posedge clk);
            #1;
            drive_cycle();
        end

        // idle a while so any extra output would show up
        @(posedge clk);
        #1;
        valid_in  = 1'b0;
        ready_out = 1'b1;
        repeat (20) @(posedge clk);

        check_value("tiles_accepted", accepted, num_tiles);
        check_value("tiles_taken", taken, num_tiles);
        check_value("expected_queue_size", exp_tile_q.size(), 0);
        if (!saw_ready_low) begin
            errors++;
            $display("ready_in never fell while the output was held back");
        end

        $display("done: %0d tiles accepted, %0d tiles taken, %0d errors",
                 accepted, taken, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/tensor_dpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "tensor_macros.svh"

// D = A*B + C for one octet, rows split over two threadgroups
module tensor_dpu
    import tensor_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     valid_in,
    output logic          ready_in,
    input  wire tile_in_t operands,
    input  wire wid_t     wid,
    output logic          valid_out,
    input  wire logic     ready_out,
    output cd_tile_t      d_tile,
    output wid_t          d_wid
);
    logic [1:0] tg_ready;
    logic [1:0] tg_valid;
    cd_frag_t   tg_d_frag [2];
    logic       wid_full;
    logic       accept;
    logic       take;
    logic       stall;

    assign ready_in  = (&tg_ready) && !wid_full;
    assign accept    = valid_in && ready_in;

    // both threadgroups see the same issue timing and stay in step
    assign valid_out = &tg_valid;
    assign take      = valid_out && ready_out;

    // output back-pressure freezes the unit pipelines
    assign stall = !ready_out;

    // B is shared, A and C rows split two per threadgroup
    for (genvar g = 0; g < 2; g++) begin : gen_tg
        tensor_threadgroup tensor_threadgroup_i (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (accept),
            .ready_in  (tg_ready[g]),
            .stall     (stall),
            .a_frag    (operands.a[2*g+1:2*g]),
            .b_tile    (operands.b),
            .c_frag    (operands.c[2*g+1:2*g]),
            .valid_out (tg_valid[g]),
            .d_frag    (tg_d_frag[g])
        );
    end

    assign d_tile = {tg_d_frag[1], tg_d_frag[0]};

    // warp ids follow the tiles in order
    fifo_queue #(
        .payload_t (wid_t),
        .depth     (`TENSOR_WID_DEPTH)
    ) wid_queue_i (
        .clk      (clk),
        .reset    (reset),
        .push     (accept),
        .pop      (take),
        .data_in  (wid),
        .data_out (d_wid),
        .empty    (),
        .full     (wid_full)
    );

endmodule

`default_nettype wire

//--- hdl/tensor_threadgroup.sv
`timescale 1ns/1ps
`default_nettype none

`include "tensor_macros.svh"

// computes a 2x4 slice of D over two steps, one column pair per step
module tensor_threadgroup
    import tensor_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     valid_in,
    output logic          ready_in,
    input  wire logic     stall,
    input  wire a_frag_t  a_frag,
    input  wire b_tile_t  b_tile,
    input  wire cd_frag_t c_frag,
    output logic          valid_out,
    output cd_frag_t      d_frag
);
    operand_frag_t       frag_in;
    operand_frag_t       head;
    logic                empty;
    logic                full;
    logic                issue;
    logic                step_in;
    logic                pop;
    logic                latch_half;
    dot_operands_t [3:0] unit_ops;
    wire logic [3:0]     unit_valid;
    wire half_t          live_half;
    half_t               first_half;

    assign frag_in.a = a_frag;
    assign frag_in.b = b_tile;
    assign frag_in.c = c_frag;

    assign ready_in = !full;

    // decouples operand arrival from the unit pipelines
    fifo_queue #(
        .payload_t (operand_frag_t),
        .depth     (`TENSOR_QUEUE_DEPTH)
    ) issue_queue_i (
        .clk      (clk),
        .reset    (reset),
        .push     (valid_in && ready_in),
        .pop      (pop),
        .data_in  (frag_in),
        .data_out (head),
        .empty    (empty),
        .full     (full)
    );

    step_sequencer step_sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .queue_valid (!empty),
        .stall       (stall),
        .units_valid (&unit_valid),
        .issue       (issue),
        .step_in     (step_in),
        .pop         (pop),
        .latch_half  (latch_half),
        .tile_valid  (valid_out)
    );

    // unit i covers row i/2, column 2*(i%2) on step 0 and the next one on step 1
    always_comb begin
        int row;
        int col;
        for (int i = 0; i < 4; i++) begin
            row = i / 2;
            col = (i % 2) * 2 + int'(step_in);
            unit_ops[i].a0 = head.a[row][0];
            unit_ops[i].a1 = head.a[row][1];
            unit_ops[i].b0 = head.b[0][col];
            unit_ops[i].b1 = head.b[1][col];
            unit_ops[i].c  = head.c[row][col];
        end
    end

    for (genvar i = 0; i < 4; i++) begin : gen_unit
        dot_product_unit dot_product_unit_i (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (issue),
            .operands  (unit_ops[i]),
            .stall     (stall),
            .out_valid (unit_valid[i]),
            .result    (live_half[i])
        );
    end

    // hold the even columns until the odd columns arrive
    always_ff @(posedge clk) begin
        if (reset) begin
            first_half <= '0;
        end else if (latch_half) begin
            first_half <= live_half;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            d_frag[i/2][(i%2)*2]     = first_half[i];
            d_frag[i/2][(i%2)*2 + 1] = live_half[i];
        end
    end

endmodule

`default_nettype wire

//--- hdl/step_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module step_sequencer (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic queue_valid,
    input  wire logic stall,
    input  wire logic units_valid,
    output logic      issue,
    output logic      step_in,
    output logic      pop,
    output logic      latch_half,
    output logic      tile_valid
);
    // step_out 0: units are producing columns 0 and 2
    // step_out 1: units are producing columns 1 and 3
    logic step_out;
    logic out_fire;

    // units are coupled to the output stall, nothing issues while frozen
    assign issue = queue_valid && !stall;

    // the head entry is consumed on its second step
    assign pop = issue && step_in;

    assign out_fire   = units_valid && !stall;
    assign latch_half = out_fire && !step_out;

    // held while stalled so the tile stays visible until taken
    assign tile_valid = units_valid && step_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            step_in  <= 1'b0;
            step_out <= 1'b0;
        end else begin
            if (issue) begin
                step_in <= ~step_in;
            end
            if (out_fire) begin
                step_out <= ~step_out;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dot_product_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "tensor_macros.svh"

module dot_product_unit
    import tensor_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          in_valid,
    input  wire dot_operands_t operands,
    input  wire logic          stall,
    output logic               out_valid,
    output elem_t              result
);
    localparam int latency = `TENSOR_DOT_LATENCY;
    // stages between the product stage and the final sum
    localparam int mid = latency - 2;

    logic [latency-1:0] valid_q;
    elem_t              prod0_q;
    elem_t              prod1_q;
    elem_t              c_q;
    elem_t              psum_q [mid];
    elem_t              carry_q [mid];
    elem_t              sum_q;

    // valid travels with the data and freezes with it
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (!stall) begin
            valid_q <= {valid_q[latency-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            // stage 1, both products and the addend
            prod0_q <= operands.a0 * operands.b0;
            prod1_q <= operands.a1 * operands.b1;
            c_q     <= operands.c;

            // partial sum, second product rides along
            psum_q[0]  <= c_q + prod0_q;
            carry_q[0] <= prod1_q;
            for (int s = 1; s < mid; s++) begin
                psum_q[s]  <= psum_q[s-1];
                carry_q[s] <= carry_q[s-1];
            end

            sum_q <= psum_q[mid-1] + carry_q[mid-1];
        end
    end

    assign out_valid = valid_q[latency-1];
    assign result    = sum_q;

endmodule

`default_nettype wire

//--- hdl/fifo_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_queue #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     push,
    input  wire logic     pop,
    input  wire payload_t data_in,
    output payload_t      data_out,
    output logic          empty,
    output logic          full
);
    localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w-1:0]   wr_ptr;
    logic [count_w-1:0] count;
    logic               do_push;
    logic               do_pop;

    // requests that cannot be served are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == count_w'(depth));

    // head is only meaningful while not empty
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves occupancy unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/tensor_pkg.sv
`default_nettype none

`include "tensor_macros.svh"

package tensor_pkg;

    typedef logic [31:0] elem_t;

    // row-major tiles, first index is the row
    typedef elem_t [3:0][1:0] a_tile_t;
    typedef elem_t [1:0][3:0] b_tile_t;
    typedef elem_t [3:0][3:0] cd_tile_t;

    // two-row slices handled by one threadgroup
    typedef elem_t [1:0][1:0] a_frag_t;
    typedef elem_t [1:0][3:0] cd_frag_t;

    // one result per unit for a single half-step
    typedef elem_t [3:0] half_t;

    typedef logic [`TENSOR_NW_WIDTH-1:0] wid_t;

    // issue queue entry
    typedef struct packed {
        a_frag_t  a;
        b_tile_t  b;
        cd_frag_t c;
    } operand_frag_t;

    // inputs of one dot-product unit for one step
    typedef struct packed {
        elem_t a0;
        elem_t a1;
        elem_t b0;
        elem_t b1;
        elem_t c;
    } dot_operands_t;

    typedef struct packed {
        a_tile_t  a;
        b_tile_t  b;
        cd_tile_t c;
    } tile_in_t;

endpackage

`default_nettype wire

//--- include/tensor_macros.svh
`ifndef TENSOR_MACROS_SVH
`define TENSOR_MACROS_SVH

// width of the warp id carried alongside each tile
`define TENSOR_NW_WIDTH 2

// operand fragments buffered per threadgroup ahead of the dot-product units
`define TENSOR_QUEUE_DEPTH 4

// pipeline stages from issue to result in each dot-product unit
`define TENSOR_DOT_LATENCY 3

// warp ids outstanding between accept and take
// sized for the issue queue plus in-flight tiles plus one, so this queue
// never fills before the threadgroup queues do
`define TENSOR_WID_DEPTH 8

`endif
